// ==== bench/l1_cache_tb.sv ====
// l1_cache testbench: clock, reset, memory responder, reference model, random requests, compare tasks
`timescale 1ns/1ps
`include "cache_config.svh"

module l1_cache_tb;

	localparam int N_RANDOM = 300;
	localparam int N_DIRECTED = 40;
	// 40 cycles per request on average, plus reset and the tag sweep
	localparam int LIMIT = (N_RANDOM + N_DIRECTED) * 40 + `CACHE_LINES + 16;
	localparam int MEM_WORDS = 8192;

	logic clk_i;
	logic rst_n;
	logic i_req_valid;
	logic o_req_ready;
	cache_pkg::cpu_req_s i_req;
	logic o_rsp_valid;
	logic i_rsp_ready;
	cache_pkg::cpu_rsp_s o_rsp;
	logic o_mem_valid;
	logic i_mem_ready;
	cache_pkg::mem_req_s o_mem;
	logic i_mem_rsp_valid;
	logic o_mem_rsp_ready;
	cache_pkg::mem_rsp_s i_mem_rsp;

	// memory behind the port, and the model of what it should hold
	logic [31:0] mem_data [MEM_WORDS];
	logic [31:0] ref_mem [MEM_WORDS];

	int seed = 32'h4c58;
	int cycle_cnt = 0;
	int mem_cnt = 0;
	logic bp_mode;
	cache_pkg::mem_req_s exp_mem;
	string cur_name;

	l1_cache dut_i (.*);

	initial begin
		clk_i = 1'b0;
		forever #20 clk_i = ~clk_i;
	end

	always @(posedge clk_i) cycle_cnt <= cycle_cnt + 1;

	initial begin
		wait (cycle_cnt >= LIMIT);
		$display("timeout: the run did not finish within %0d cycles", LIMIT);
		abort_run();
	end

	task automatic abort_run();
		$display("TEST FAIL");
		$fatal(1, "simulation stopped");
	endtask

	function automatic string mem_text(cache_pkg::mem_req_s m);
		return $sformatf("addr %h we %b burst %b wdata %h strb %h",
			m.addr, m.we, m.burst, m.wdata, m.strb);
	endfunction

	task automatic check_rsp(string name, cache_pkg::cpu_rsp_s exp, cache_pkg::cpu_rsp_s act);
		if (act !== exp) begin
			$display("[FAIL] %s: expected rdata %h, actual rdata %h", name, exp.rdata, act.rdata);
			abort_run();
		end
	endtask

	task automatic check_mem_req(string name, cache_pkg::mem_req_s exp, cache_pkg::mem_req_s act);
		if (act !== exp) begin
			$display("[FAIL] %s: expected %s, actual %s", name, mem_text(exp), mem_text(act));
			abort_run();
		end
	endtask

	// spreads every word address over the whole data word
	function automatic logic [31:0] pattern_word(int i);
		return (i * 32'h9e37_79b1) ^ {16'(i), 16'hc3a5};
	endfunction

	function automatic logic [31:0] merge_bytes(logic [31:0] old, logic [31:0] wdata,
		logic [3:0] strb);
		logic [31:0] r;
		r = old;
		for (int b = 0; b < 4; b++) begin
			if (strb[b]) r[b*8 +: 8] = wdata[b*8 +: 8];
		end
		return r;
	endfunction

	// memory accepts after a random delay and answers beats in wrap order
	initial begin : mem_responder
		cache_pkg::mem_req_s req;
		int delay;
		int beats;
		int base;
		int idx;
		logic taken;
		forever begin
			@(negedge clk_i);
			if (o_mem_valid) begin
				req = o_mem;
				delay = $unsigned($random(seed)) % 4;
				repeat (delay) @(posedge clk_i);
				@(posedge clk_i);
				#2 i_mem_ready = 1'b1;
				@(posedge clk_i);
				#2 i_mem_ready = 1'b0;
				mem_cnt++;
				check_mem_req({cur_name, " mem request"}, exp_mem, req);
				base = req.addr[14:2];
				if (req.we) mem_data[base] = merge_bytes(mem_data[base], req.wdata, req.strb);
				beats = req.burst ? 4 : 1;
				for (int b = 0; b < beats; b++) begin
					delay = $unsigned($random(seed)) % 4;
					repeat (delay) begin
						@(posedge clk_i);
						#2;
					end
					idx = {req.addr[14:4], 2'(req.addr[3:2] + b)};
					i_mem_rsp.rdata = mem_data[idx];
					i_mem_rsp.last = (b == beats - 1);
					i_mem_rsp_valid = 1'b1;
					do begin
						@(negedge clk_i);
						taken = o_mem_rsp_ready;
						@(posedge clk_i);
						#2;
					end while (!taken);
					i_mem_rsp_valid = 1'b0;
				end
			end
		end
	end

	// drives one request end to end
	// exp_cnt is the expected memory request count, and -1 accepts any count
	task automatic run_req(string name, logic we, logic cacheable, logic [31:0] addr,
		logic [31:0] wdata, logic [3:0] strb, int exp_cnt);
		cache_pkg::cpu_rsp_s exp_rsp;
		cache_pkg::cpu_rsp_s held;
		int start_cnt;
		int lat;
		int w;
		logic seen;
		logic accepted;
		logic done;
		w = addr[14:2];
		cur_name = name;
		exp_mem.addr = addr;
		exp_mem.we = we;
		exp_mem.burst = cacheable && !we;
		exp_mem.wdata = wdata;
		exp_mem.strb = strb;
		exp_rsp.rdata = we ? 32'h0 : ref_mem[w];
		if (we) ref_mem[w] = merge_bytes(ref_mem[w], wdata, strb);
		start_cnt = mem_cnt;
		i_req.addr.flat = addr;
		i_req.we = we;
		i_req.cacheable = cacheable;
		i_req.wdata = wdata;
		i_req.strb = strb;
		i_req_valid = 1'b1;
		accepted = 1'b0;
		while (!accepted) begin
			@(negedge clk_i);
			accepted = o_req_ready;
			@(posedge clk_i);
			#2;
		end
		i_req_valid = 1'b0;
		lat = 0;
		seen = 1'b0;
		done = 1'b0;
		while (!done) begin
			i_rsp_ready = !bp_mode || ($random(seed) % 2 == 0);
			@(negedge clk_i);
			lat++;
			if (o_rsp_valid) begin
				if (seen) check_rsp({name, " held payload"}, held, o_rsp);
				if (!seen && exp_cnt == 0 && lat != 4) begin
					$display("[FAIL] %s: expected hit latency 4, actual %0d", name, lat);
					abort_run();
				end
				held = o_rsp;
				seen = 1'b1;
				done = i_rsp_ready;
			end else if (seen) begin
				$display("%s: response valid dropped before the processor took it", name);
				abort_run();
			end
			@(posedge clk_i);
			#2;
		end
		check_rsp(name, exp_rsp, held);
		if (exp_cnt >= 0 && mem_cnt - start_cnt != exp_cnt) begin
			$display("[FAIL] %s: expected %0d memory requests, actual %0d",
				name, exp_cnt, mem_cnt - start_cnt);
			abort_run();
		end
	endtask

	initial begin : stimulus
		logic [31:0] r;
		logic [31:0] d;
		logic [31:0] a;
		int sweep_cycles;
		for (int i = 0; i < MEM_WORDS; i++) begin
			mem_data[i] = pattern_word(i);
			ref_mem[i] = pattern_word(i);
		end
		rst_n = 1'b0;
		i_req_valid = 1'b0;
		i_req = '0;
		i_rsp_ready = 1'b0;
		i_mem_ready = 1'b0;
		i_mem_rsp_valid = 1'b0;
		i_mem_rsp = '0;
		bp_mode = 1'b0;
		exp_mem = '0;
		repeat (16) @(posedge clk_i);
		#2 rst_n = 1'b1;

		// ports stay idle while every set is swept
		sweep_cycles = 0;
		@(negedge clk_i);
		while (!o_req_ready) begin
			if (o_rsp_valid || o_mem_valid || o_mem_rsp_ready) begin
				$display("[FAIL] reset_idle: expected rsp/mem/mem_rsp valid-ready 000, actual %b%b%b",
					o_rsp_valid, o_mem_valid, o_mem_rsp_ready);
				abort_run();
			end
			sweep_cycles++;
			@(negedge clk_i);
		end
		if (sweep_cycles < `CACHE_LINES) begin
			$display("[FAIL] sweep_wait: expected at least %0d cycles before ready, actual %0d",
				`CACHE_LINES, sweep_cycles);
			abort_run();
		end
		@(posedge clk_i);
		#2;

		// miss fills the line, then two hits in it
		run_req("miss_fill", 1'b0, 1'b1, 32'h0000_0128, 32'h0, 4'h0, 1);
		run_req("hit_same", 1'b0, 1'b1, 32'h0000_0128, 32'h0, 4'h0, 0);
		run_req("hit_other_word", 1'b0, 1'b1, 32'h0000_0124, 32'h0, 4'h0, 0);

		// write hit merges, write miss only goes to memory
		run_req("write_hit", 1'b1, 1'b1, 32'h0000_0128, 32'hdead_beef, 4'b0101, 1);
		run_req("read_merged", 1'b0, 1'b1, 32'h0000_0128, 32'h0, 4'h0, 0);
		run_req("write_miss", 1'b1, 1'b1, 32'h0000_0234, 32'h1234_5678, 4'b1110, 1);
		run_req("read_after_miss", 1'b0, 1'b1, 32'h0000_0234, 32'h0, 4'h0, 1);

		run_req("bypass_read", 1'b0, 1'b0, 32'h0000_4010, 32'h0, 4'h0, 1);
		run_req("bypass_write", 1'b1, 1'b0, 32'h0000_4010, 32'hcafe_f00d, 4'hf, 1);
		run_req("bypass_readback", 1'b0, 1'b0, 32'h0000_4010, 32'h0, 4'h0, 1);

		// six tags into set 9 of a four-way cache
		for (int t = 0; t < 6; t++) begin
			run_req("evict_fill", 1'b0, 1'b1, (t << 10) | 32'h94, 32'h0, 4'h0, 1);
		end
		for (int t = 0; t < 6; t++) begin
			run_req("evict_check", 1'b0, 1'b1, (t << 10) | 32'h98, 32'h0, 4'h0, -1);
		end

		bp_mode = 1'b1;
		for (int k = 0; k < 6; k++) begin
			run_req("bp_fill", 1'b0, 1'b1, 32'h0000_0c0c | (k << 4), 32'h0, 4'h0, 1);
			run_req("bp_hit", 1'b0, 1'b1, 32'h0000_0c0c | (k << 4), 32'h0, 4'h0, 0);
		end

		// random mix over four tags and four sets, plus a small uncached window
		for (int n = 0; n < N_RANDOM; n++) begin
			r = $random(seed);
			d = $random(seed);
			bp_mode = r[0];
			if (r[3:1] == 3'd0) begin
				a = 32'h0000_4000 | {r[9:4], 2'b00};
				if (r[10]) run_req("rand_bypass_write", 1'b1, 1'b0, a, d, r[14:11], 1);
				else run_req("rand_bypass_read", 1'b0, 1'b0, a, 32'h0, 4'h0, 1);
			end else begin
				a = {20'h0, r[17:16], 4'h0, r[19:18], r[21:20], 2'b00};
				if (r[10]) run_req("rand_write", 1'b1, 1'b1, a, d, r[14:11], 1);
				else run_req("rand_read", 1'b0, 1'b1, a, 32'h0, 4'h0, -1);
			end
		end

		$display("TEST PASS");
		$finish;
	end

endmodule

// ==== list.f ====
+incdir+rtl
rtl/cache_pkg.sv
rtl/tag_store.sv
rtl/line_store.sv
rtl/cache_ctrl.sv
rtl/l1_cache.sv
bench/l1_cache_tb.sv

// ==== rtl/cache_config.svh ====
// cache geometry macros: ways, sets, words per line, address width and derived field widths
`ifndef CACHE_CONFIG_SVH
`define CACHE_CONFIG_SVH

// associativity
`define CACHE_WAYS 4

// number of sets, small so the reset sweep stays short
`define CACHE_LINES 64

// words per line, the fill logic assumes four
`define CACHE_WORDS 4

// byte address width
`define CACHE_ADDR_W 32

// derived widths
`define CACHE_WAY_W ($clog2(`CACHE_WAYS))
`define CACHE_INDEX_W ($clog2(`CACHE_LINES))
`define CACHE_WSEL_W ($clog2(`CACHE_WORDS))
`define CACHE_TAG_W (`CACHE_ADDR_W - `CACHE_INDEX_W - `CACHE_WSEL_W - 2)
`define CACHE_LINE_W (`CACHE_WORDS * 32)

`endif

// ==== rtl/cache_ctrl.sv ====
// cache controller FSM: hit check, readback, wrap fill, write-through and uncached bypass
`timescale 1ns/1ps
`include "cache_config.svh"

module cache_ctrl (
	input  logic                       clk_i,
	input  logic                       rst_n,
	input  logic                       i_req_valid,
	output logic                       o_req_ready,
	input  cache_pkg::cpu_req_s        i_req,
	output logic                       o_rsp_valid,
	input  logic                       i_rsp_ready,
	output cache_pkg::cpu_rsp_s        o_rsp,
	output logic                       o_mem_valid,
	input  logic                       i_mem_ready,
	output cache_pkg::mem_req_s        o_mem,
	input  logic                       i_mem_rsp_valid,
	output logic                       o_mem_rsp_ready,
	input  cache_pkg::mem_rsp_s        i_mem_rsp,
	output cache_pkg::index_t          o_index,
	output cache_pkg::tag_t            o_tag,
	output logic                       o_tag_we,
	output cache_pkg::way_t            o_way,
	output logic                       o_tag_valid,
	input  logic                       i_hit,
	input  cache_pkg::way_t            i_hit_way,
	input  cache_pkg::way_t            i_victim,
	input  logic                       i_sweep_busy,
	output logic                       o_line_we,
	output cache_pkg::line_t           o_line_wdata,
	output logic [`CACHE_WORDS*4-1:0]  o_line_be,
	output logic [`CACHE_WSEL_W-1:0]   o_word,
	input  logic [31:0]                i_word_data
);

	localparam int BE_W = `CACHE_WORDS * 4;

	typedef enum logic [3:0] {
		ST_SWEEP, ST_IDLE, ST_CHK1, ST_CHK2, ST_CHK3, ST_READBACK,
		ST_FILL_REQ, ST_FILL_DATA, ST_FILL_STALL, ST_MEM_REQ, ST_MEM_RSP, ST_RESP
	} state_e;

	state_e state;
	cache_pkg::cpu_req_s req_q;
	cache_pkg::cache_addr_u fill_addr;
	cache_pkg::way_t way_q;
	cache_pkg::line_t fill_buf;
	cache_pkg::line_t fill_line;
	logic merge_q;
	logic [2:0] fill_cnt;
	logic [`CACHE_WSEL_W-1:0] fill_word;
	logic [31:0] rdata_q;
	logic [31:0] stall_q;
	logic [BE_W-1:0] merge_be;
	logic mem_beat;
	logic last_beat;

	assign mem_beat = i_mem_rsp_valid && o_mem_rsp_ready;
	assign last_beat = mem_beat && state == ST_FILL_DATA && fill_cnt == 3'(`CACHE_WORDS - 1);

	always_ff @(posedge clk_i) begin
		if (!rst_n) begin
			state <= ST_SWEEP;
			merge_q <= 1'b0;
			fill_cnt <= '0;
		end else begin
			case (state)
				ST_SWEEP: if (!i_sweep_busy) state <= ST_IDLE;
				ST_IDLE: begin
					merge_q <= 1'b0;
					if (i_req_valid) state <= i_req.cacheable ? ST_CHK1 : ST_MEM_REQ;
				end
				ST_CHK1: state <= ST_CHK2;
				ST_CHK2: state <= ST_CHK3;
				ST_CHK3: begin
					merge_q <= i_hit && req_q.we;
					if (req_q.we) state <= ST_MEM_REQ;
					else if (i_hit) state <= ST_READBACK;
					else state <= ST_FILL_REQ;
				end
				ST_FILL_REQ: begin
					fill_cnt <= '0;
					if (i_mem_ready) state <= ST_FILL_DATA;
				end
				ST_FILL_DATA: begin
					if (last_beat) begin
						state <= ST_IDLE;
					end else if (mem_beat) begin
						fill_cnt <= fill_cnt + 1'b1;
						// first word not taken yet, park it
						if (fill_cnt == '0 && !i_rsp_ready) state <= ST_FILL_STALL;
					end
				end
				ST_FILL_STALL: if (i_rsp_ready) state <= ST_FILL_DATA;
				ST_MEM_REQ: if (i_mem_ready) state <= ST_MEM_RSP;
				ST_MEM_RSP: if (i_mem_rsp_valid) state <= ST_RESP;
				ST_READBACK, ST_RESP: if (i_rsp_ready) state <= ST_IDLE;
				default: state <= ST_IDLE;
			endcase
		end
	end

	// request and fill payload
	always_ff @(posedge clk_i) begin
		if (state == ST_IDLE && i_req_valid) req_q <= i_req;
		if (state == ST_CHK3) way_q <= i_hit ? i_hit_way : i_victim;
		if (state == ST_FILL_REQ) fill_word <= req_q.addr.fields.word;
		if (state == ST_FILL_DATA && mem_beat) begin
			fill_buf <= fill_line;
			fill_word <= fill_word + 1'b1;
			if (fill_cnt == '0) stall_q <= i_mem_rsp.rdata;
		end
		if (state == ST_MEM_RSP && i_mem_rsp_valid) rdata_q <= req_q.we ? '0 : i_mem_rsp.rdata;
	end

	// beat merged into the line being gathered
	always_comb begin
		fill_line = fill_buf;
		fill_line[fill_word*32 +: 32] = i_mem_rsp.rdata;
	end

	// wrap burst starts at the requested word
	always_comb begin
		fill_addr = req_q.addr;
		fill_addr.fields.offset = '0;
	end

	assign merge_be = BE_W'(req_q.strb) << {req_q.addr.fields.word, 2'b00};

	assign o_req_ready = state == ST_IDLE;
	assign o_mem_valid = state == ST_FILL_REQ || state == ST_MEM_REQ;
	assign o_mem_rsp_ready = state == ST_FILL_DATA || state == ST_MEM_RSP;
	assign o_mem.addr = (state == ST_FILL_REQ) ? fill_addr.flat : req_q.addr.flat;
	assign o_mem.we = req_q.we;
	assign o_mem.burst = state == ST_FILL_REQ;
	assign o_mem.wdata = req_q.wdata;
	assign o_mem.strb = req_q.strb;

	assign o_rsp_valid = state == ST_READBACK || state == ST_RESP || state == ST_FILL_STALL
		|| (state == ST_FILL_DATA && fill_cnt == '0 && i_mem_rsp_valid);

	always_comb begin
		case (state)
			ST_READBACK: o_rsp.rdata = i_word_data;
			ST_FILL_STALL: o_rsp.rdata = stall_q;
			ST_FILL_DATA: o_rsp.rdata = i_mem_rsp.rdata;
			default: o_rsp.rdata = rdata_q;
		endcase
	end

	// tag and line side
	assign o_index = req_q.addr.fields.index;
	assign o_tag = req_q.addr.fields.tag;
	assign o_tag_we = last_beat;
	assign o_tag_valid = 1'b1;
	assign o_way = way_q;
	assign o_word = req_q.addr.fields.word;
	assign o_line_we = last_beat || (state == ST_MEM_REQ && i_mem_ready && merge_q);
	assign o_line_wdata = (state == ST_FILL_DATA) ? fill_line : {`CACHE_WORDS{req_q.wdata}};
	assign o_line_be = (state == ST_FILL_DATA) ? '1 : merge_be;

	// memory request is held with its payload until taken
	a_mem_hold: assert property (@(posedge clk_i) disable iff (!rst_n)
		o_mem_valid && !i_mem_ready |=> o_mem_valid && $stable(o_mem));

	// the counter reaches three exactly on the burst's last beat
	a_fill_cnt: assert property (@(posedge clk_i) disable iff (!rst_n)
		state == ST_FILL_DATA && mem_beat |-> (fill_cnt == 3'd3) == i_mem_rsp.last);

endmodule

// ==== rtl/cache_pkg.sv ====
// cache types: way, tag, index and line types, address union, request and response structs
`include "cache_config.svh"

package cache_pkg;

	typedef logic [`CACHE_WAY_W-1:0] way_t;
	typedef logic [`CACHE_TAG_W-1:0] tag_t;
	typedef logic [`CACHE_INDEX_W-1:0] index_t;
	typedef logic [`CACHE_LINE_W-1:0] line_t;

	// one address word, seen flat or split into cache fields
	typedef union packed {
		logic [`CACHE_ADDR_W-1:0] flat;
		struct packed {
			tag_t tag;
			index_t index;
			logic [`CACHE_WSEL_W-1:0] word;
			logic [1:0] offset;
		} fields;
	} cache_addr_u;

	// processor request
	typedef struct packed {
		cache_addr_u addr;
		logic we;
		logic cacheable;
		logic [31:0] wdata;
		logic [3:0] strb;
	} cpu_req_s;

	typedef struct packed {
		logic [31:0] rdata;
	} cpu_rsp_s;

	// memory request, burst set for a four-beat wrap
	typedef struct packed {
		logic [`CACHE_ADDR_W-1:0] addr;
		logic we;
		logic burst;
		logic [31:0] wdata;
		logic [3:0] strb;
	} mem_req_s;

	typedef struct packed {
		logic [31:0] rdata;
		logic last;
	} mem_rsp_s;

endpackage

// ==== rtl/l1_cache.sv ====
// L1 cache top: controller, tag store and line store
`timescale 1ns/1ps
`include "cache_config.svh"

module l1_cache (
	input  logic                 clk_i,
	input  logic                 rst_n,
	input  logic                 i_req_valid,
	output logic                 o_req_ready,
	input  cache_pkg::cpu_req_s  i_req,
	output logic                 o_rsp_valid,
	input  logic                 i_rsp_ready,
	output cache_pkg::cpu_rsp_s  o_rsp,
	output logic                 o_mem_valid,
	input  logic                 i_mem_ready,
	output cache_pkg::mem_req_s  o_mem,
	input  logic                 i_mem_rsp_valid,
	output logic                 o_mem_rsp_ready,
	input  cache_pkg::mem_rsp_s  i_mem_rsp
);

	// tag side
	cache_pkg::index_t index;
	cache_pkg::tag_t tag;
	cache_pkg::way_t way;
	cache_pkg::way_t hit_way;
	cache_pkg::way_t victim;
	logic tag_we;
	logic tag_valid;
	logic hit;
	logic sweep_busy;

	// line side
	cache_pkg::line_t line_wdata;
	logic [`CACHE_WORDS*4-1:0] line_be;
	logic [`CACHE_WSEL_W-1:0] word;
	logic [31:0] word_data;
	logic line_we;

	cache_ctrl ctrl_i (
		.clk_i, .rst_n, .i_req_valid, .o_req_ready, .i_req, .o_rsp_valid, .i_rsp_ready,
		.o_rsp, .o_mem_valid, .i_mem_ready, .o_mem, .i_mem_rsp_valid, .o_mem_rsp_ready,
		.i_mem_rsp, .o_index(index), .o_tag(tag), .o_tag_we(tag_we), .o_way(way),
		.o_tag_valid(tag_valid), .i_hit(hit), .i_hit_way(hit_way), .i_victim(victim),
		.i_sweep_busy(sweep_busy), .o_line_we(line_we), .o_line_wdata(line_wdata),
		.o_line_be(line_be), .o_word(word), .i_word_data(word_data)
	);

	tag_store tags_i (
		.clk_i, .rst_n, .i_index(index), .i_tag(tag), .i_tag_we(tag_we), .i_way(way),
		.i_tag_valid(tag_valid), .o_hit(hit), .o_hit_way(hit_way), .o_victim(victim),
		.o_sweep_busy(sweep_busy)
	);

	line_store lines_i (
		.clk_i, .i_index(index), .i_way(way), .i_we(line_we), .i_wdata(line_wdata),
		.i_be(line_be), .i_word(word), .o_word_data(word_data)
	);

endmodule

// ==== rtl/line_store.sv ====
// line store: per-way line data arrays, byte-enabled writes, word select on read
`timescale 1ns/1ps
`include "cache_config.svh"

module line_store (
	input  logic                       clk_i,
	input  cache_pkg::index_t          i_index,
	input  cache_pkg::way_t            i_way,
	input  logic                       i_we,
	input  cache_pkg::line_t           i_wdata,
	input  logic [`CACHE_WORDS*4-1:0]  i_be,
	input  logic [`CACHE_WSEL_W-1:0]   i_word,
	output logic [31:0]                o_word_data
);

	localparam int WAYS = `CACHE_WAYS;
	localparam int LINES = `CACHE_LINES;
	localparam int BYTES = `CACHE_WORDS * 4;

	cache_pkg::line_t line_mem [WAYS][LINES];

	// read address, one cycle behind the index
	cache_pkg::index_t index_q;
	cache_pkg::line_t rd_line;

	always_ff @(posedge clk_i) begin
		index_q <= i_index;
		if (i_we) begin
			for (int b = 0; b < BYTES; b++) begin
				if (i_be[b]) begin
					line_mem[i_way][i_index][b*8 +: 8] <= i_wdata[b*8 +: 8];
				end
			end
		end
	end

	// combinational read of the selected way
	assign rd_line = line_mem[i_way][index_q];

	// word select inside the line
	assign o_word_data = rd_line[i_word*32 +: 32];

endmodule

// ==== rtl/tag_store.sv ====
// tag store: per-way tag and valid arrays, parallel hit compare, victim choice, reset sweep
`timescale 1ns/1ps
`include "cache_config.svh"

module tag_store (
	input  logic                clk_i,
	input  logic                rst_n,
	input  cache_pkg::index_t   i_index,
	input  cache_pkg::tag_t     i_tag,
	input  logic                i_tag_we,
	input  cache_pkg::way_t     i_way,
	input  logic                i_tag_valid,
	output logic                o_hit,
	output cache_pkg::way_t     o_hit_way,
	output cache_pkg::way_t     o_victim,
	output logic                o_sweep_busy
);

	localparam int WAYS = `CACHE_WAYS;
	localparam int LINES = `CACHE_LINES;

	cache_pkg::tag_t tag_mem [WAYS][LINES];
	logic [LINES-1:0] valid_mem [WAYS];

	logic [WAYS-1:0] match_q;
	logic [WAYS-1:0] valid_q;
	cache_pkg::index_t sweep_cnt;
	logic sweep_busy;
	cache_pkg::way_t rr_cnt;

	// sweep walks every set once after reset
	always_ff @(posedge clk_i) begin
		if (!rst_n) begin
			sweep_busy <= 1'b1;
			sweep_cnt <= '0;
			rr_cnt <= '0;
		end else begin
			rr_cnt <= rr_cnt + 1'b1;
			if (sweep_busy) begin
				sweep_cnt <= sweep_cnt + 1'b1;
				if (sweep_cnt == cache_pkg::index_t'(LINES - 1)) begin
					sweep_busy <= 1'b0;
				end
			end
		end
	end

	// array writes: sweep clears valid, a fill installs the tag
	always_ff @(posedge clk_i) begin
		for (int w = 0; w < WAYS; w++) begin
			if (sweep_busy) begin
				valid_mem[w][sweep_cnt] <= 1'b0;
			end else if (i_tag_we && i_way == cache_pkg::way_t'(w)) begin
				tag_mem[w][i_index] <= i_tag;
				valid_mem[w][i_index] <= i_tag_valid;
			end
		end
	end

	// lookup result one cycle after the index
	always_ff @(posedge clk_i) begin
		for (int w = 0; w < WAYS; w++) begin
			valid_q[w] <= valid_mem[w][i_index];
			match_q[w] <= valid_mem[w][i_index] && (tag_mem[w][i_index] == i_tag);
		end
	end

	// highest matching way wins
	always_comb begin
		o_hit_way = '0;
		for (int w = 0; w < WAYS; w++) begin
			if (match_q[w]) o_hit_way = cache_pkg::way_t'(w);
		end
	end

	// first invalid way, else round robin
	always_comb begin
		o_victim = rr_cnt;
		for (int w = WAYS - 1; w >= 0; w--) begin
			if (!valid_q[w]) o_victim = cache_pkg::way_t'(w);
		end
	end

	assign o_hit = |match_q;
	assign o_sweep_busy = sweep_busy;

	// fills only go to a missing line, so a tag never sits in two ways of one set
	a_single_match: assert property (@(posedge clk_i) disable iff (!rst_n)
		o_hit |-> $onehot(match_q));

endmodule

// ==== run.sh ====
#!/bin/sh
# build and run the l1_cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f list.f --top-module l1_cache_tb -o l1_cache_sim
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

out=$(./obj_dir/l1_cache_sim)
rc=$?
echo "$out"
if [ $rc -ne 0 ]; then
	echo "simulation exited with status $rc"
	exit 1
fi
if echo "$out" | grep -qx "TEST PASS"; then
	exit 0
fi
exit 1
